//--- logic/muldiv_pkg.sv
// Multiply/divide unit shared definitions
// Word width, opcode and FSM state encodings, step counts
`default_nettype none

package muldiv_pkg;

  // Operand and result width of the core
  localparam int unsigned XLEN = 32;

  //////////////////////////////////////////////////////////////////////////
  // Opcodes
  //////////////////////////////////////////////////////////////////////////

  // Bit 2 set means a divide class opcode
  typedef enum logic [2:0] {
    OP_MUL    = 3'd0,
    OP_MULH   = 3'd1,
    OP_MULHSU = 3'd2,
    OP_MULHU  = 3'd3,
    OP_DIV    = 3'd4,
    OP_DIVU   = 3'd5,
    OP_REM    = 3'd6,
    OP_REMU   = 3'd7
  } muldiv_op_e;

  //////////////////////////////////////////////////////////////////////////
  // Sequencing FSM
  //////////////////////////////////////////////////////////////////////////

  typedef enum logic [2:0] {
    // Operands seen, first step loaded
    ST_IDLE      = 3'd0,
    // Iterating over the Booth or divide steps
    ST_EXEC      = 3'd1,
    // Divide only, decide if a correction is needed
    ST_REMD_CHCK = 3'd2,
    // Quotient plus or minus one
    ST_QUOT_CORR = 3'd3,
    // Remainder plus or minus divisor
    ST_REMD_CORR = 3'd4
  } muldiv_state_e;

  // Counter value of the last exec cycle
  localparam int unsigned MUL_STEPS = 16;
  localparam int unsigned DIV_STEPS = 32;

  // Wide enough to hold DIV_STEPS
  localparam int unsigned CNT_W = 6;

endpackage : muldiv_pkg

`default_nettype wire

//--- logic/muldiv_ctrl.sv
// Multiply/divide sequencer
// Holds the FSM state and step counter and issues the per-step
// strobes for the Booth multiplier and the non-restoring divider
`timescale 1ns/10ps
`default_nettype none

module muldiv_ctrl (
  input  logic                   clk,
  input  logic                   i_arst_n,
  input  logic                   i_valid,
  input  muldiv_pkg::muldiv_op_e i_op,
  input  logic                   i_special,
  input  logic                   i_retire,
  input  logic                   i_div_need_corr,
  output logic                   o_mul_load,
  output logic                   o_mul_iter,
  output logic                   o_mul_last,
  output logic                   o_div_load,
  output logic                   o_div_iter,
  output logic                   o_div_last,
  output logic                   o_div_chck,
  output logic                   o_quot_corr,
  output logic                   o_remd_corr,
  output logic                   o_done
);

  import muldiv_pkg::*;

  muldiv_state_e    state_r;
  muldiv_state_e    state_nxt;
  logic [CNT_W-1:0] step_cnt_r;
  logic             is_mul;
  logic             st_idle;
  logic             st_exec;
  logic             exec_last;
  logic             start;

  // Multiply opcodes take the 16 step path, the rest divide
  assign is_mul = (i_op == OP_MUL) | (i_op == OP_MULH) |
                  (i_op == OP_MULHSU) | (i_op == OP_MULHU);

  assign st_idle = (state_r == ST_IDLE);
  assign st_exec = (state_r == ST_EXEC);

  // Special cases answer from idle without leaving it
  assign start = st_idle & i_valid & ~i_special;

  // Last exec cycle depends on the opcode class
  assign exec_last = is_mul ? (step_cnt_r == CNT_W'(MUL_STEPS))
                            : (step_cnt_r == CNT_W'(DIV_STEPS));

  //////////////////////////////////////////////////////////////////////////
  // Next state
  //////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_nxt = state_r;
    case (state_r)
      ST_IDLE: begin
        if (start) begin
          state_nxt = ST_EXEC;
        end
      end
      ST_EXEC: begin
        // Divide always goes on to the check, multiply waits for the sink
        if (exec_last & ~is_mul) begin
          state_nxt = ST_REMD_CHCK;
        end else if (exec_last & i_retire) begin
          state_nxt = ST_IDLE;
        end
      end
      ST_REMD_CHCK: begin
        if (i_div_need_corr) begin
          state_nxt = ST_QUOT_CORR;
        end else if (i_retire) begin
          state_nxt = ST_IDLE;
        end
      end
      // One cycle only
      ST_QUOT_CORR: state_nxt = ST_REMD_CORR;
      ST_REMD_CORR: begin
        if (i_retire) begin
          state_nxt = ST_IDLE;
        end
      end
      default: state_nxt = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state_r    <= ST_IDLE;
      step_cnt_r <= '0;
    end else begin
      state_r <= state_nxt;
      // Idle cycle counts as step zero, so exec starts at one
      if (start) begin
        step_cnt_r <= CNT_W'(1);
      end else if (st_exec & ~exec_last) begin
        step_cnt_r <= step_cnt_r + CNT_W'(1);
      end
    end
  end

  // Multiplier strobes
  assign o_mul_load = st_idle & i_valid & is_mul;
  assign o_mul_iter = st_exec & is_mul & ~exec_last;
  assign o_mul_last = st_exec & is_mul & exec_last;

  // Divider strobes
  assign o_div_load  = start & ~is_mul;
  assign o_div_iter  = st_exec & ~is_mul & ~exec_last;
  assign o_div_last  = st_exec & ~is_mul & exec_last;
  assign o_div_chck  = (state_r == ST_REMD_CHCK);
  assign o_quot_corr = (state_r == ST_QUOT_CORR);
  assign o_remd_corr = (state_r == ST_REMD_CORR);

  // Result ready for write-back
  assign o_done = o_mul_last | (o_div_chck & ~i_div_need_corr) | o_remd_corr;

endmodule : muldiv_ctrl

`default_nettype wire

//--- logic/booth_mul_dpath.sv
// Radix-4 Booth multiplier datapath
// Sign-extended 33x33 product in sixteen register steps plus a final
// combinational add, with its own 35-bit adder
`timescale 1ns/10ps
`default_nettype none

module booth_mul_dpath (
  input  logic                        clk,
  input  logic                        i_arst_n,
  input  muldiv_pkg::muldiv_op_e      i_op,
  input  logic [muldiv_pkg::XLEN-1:0] i_rs1,
  input  logic [muldiv_pkg::XLEN-1:0] i_rs2,
  input  logic                        i_load,
  input  logic                        i_iter,
  input  logic                        i_last,
  output logic [muldiv_pkg::XLEN-1:0] o_mul_res
);

  import muldiv_pkg::*;

  logic            rs1_sign;
  logic            rs2_sign;
  logic [XLEN:0]   prdt_hi_r;
  logic [XLEN:0]   prdt_lo_r;
  logic            prdt_sft1_r;
  logic [2:0]      booth_code;
  logic            sel_zero;
  logic            sel_two;
  logic            sel_sub;
  logic [XLEN+2:0] add_op1;
  logic [XLEN+2:0] add_op2;
  logic [XLEN+2:0] add_res;

  // MULHU is unsigned by unsigned, MULHSU has an unsigned rs2
  assign rs1_sign = (i_op == OP_MULHU) ? 1'b0 : i_rs1[XLEN-1];
  assign rs2_sign = ((i_op == OP_MULHSU) | (i_op == OP_MULHU)) ? 1'b0 : i_rs2[XLEN-1];

  // Bit pairs of rs1 plus the bit below, last digit sees the extended sign
  assign booth_code = i_load ? {i_rs1[1:0], 1'b0} :
                      i_last ? {rs1_sign, prdt_lo_r[0], prdt_sft1_r} :
                               {prdt_lo_r[1:0], prdt_sft1_r};

  // 000 and 111 add nothing, 011 and 100 take twice rs2
  assign sel_zero = (booth_code == 3'b000) | (booth_code == 3'b111);
  assign sel_two  = (booth_code == 3'b011) | (booth_code == 3'b100);
  assign sel_sub  = booth_code[2];

  always_comb begin
    if (sel_zero) begin
      add_op2 = '0;
    end else if (sel_two) begin
      add_op2 = {rs2_sign, rs2_sign, i_rs2, 1'b0};
    end else begin
      add_op2 = {rs2_sign, rs2_sign, rs2_sign, i_rs2};
    end
  end

  // Running high partial product, sign-extended to the adder width
  assign add_op1 = i_load ? '0 : {prdt_hi_r[XLEN], prdt_hi_r[XLEN], prdt_hi_r};
  assign add_res = add_op1 + (add_op2 ^ {(XLEN+3){sel_sub}}) + {{(XLEN+2){1'b0}}, sel_sub};

  // Shift right by two each step, product bits enter the low register
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      prdt_hi_r   <= '0;
      prdt_lo_r   <= '0;
      prdt_sft1_r <= 1'b0;
    end else if (i_load) begin
      prdt_hi_r   <= add_res[XLEN+2:2];
      prdt_lo_r   <= {add_res[1:0], rs1_sign, i_rs1[XLEN-1:2]};
      prdt_sft1_r <= i_rs1[1];
    end else if (i_iter) begin
      prdt_hi_r   <= add_res[XLEN+2:2];
      prdt_lo_r   <= {add_res[1:0], prdt_lo_r[XLEN:2]};
      prdt_sft1_r <= prdt_lo_r[1];
    end
  end

  // Low word is already shifted in, high word comes from the final add
  assign o_mul_res = (i_op == OP_MUL) ? prdt_lo_r[XLEN:1] : add_res[XLEN-1:0];

endmodule : booth_mul_dpath

`default_nettype wire

//--- logic/nonrestore_div_dpath.sv
// Non-restoring divider datapath
// Thirty-two add/subtract steps, a remainder check, then optional
// quotient and remainder correction, all on one 34-bit adder
`timescale 1ns/10ps
`default_nettype none

module nonrestore_div_dpath (
  input  logic                        clk,
  input  logic                        i_arst_n,
  input  muldiv_pkg::muldiv_op_e      i_op,
  input  logic [muldiv_pkg::XLEN-1:0] i_rs1,
  input  logic [muldiv_pkg::XLEN-1:0] i_rs2,
  input  logic                        i_load,
  input  logic                        i_iter,
  input  logic                        i_last,
  input  logic                        i_chck,
  input  logic                        i_quot_corr,
  input  logic                        i_remd_corr,
  output logic                        o_need_corr,
  output logic [muldiv_pkg::XLEN-1:0] o_div_res
);

  import muldiv_pkg::*;

  logic            is_unsigned;
  logic            rs1_sign;
  logic            rs2_sign;
  logic [XLEN+1:0] divisor;
  logic            quot_first;
  logic [XLEN:0]   remd_r;
  logic [XLEN:0]   quot_r;
  logic            remd_sft1_r;
  logic            prev_quot;
  logic            cur_quot;
  logic [XLEN:0]   part_lo;
  logic [XLEN+1:0] add_op1;
  logic [XLEN+1:0] add_op2;
  logic            add_sub;
  logic [XLEN+1:0] add_res;
  logic            remd_inc_quot_dec;
  logic [XLEN:0]   div_remd;

  assign is_unsigned = (i_op == OP_DIVU) | (i_op == OP_REMU);
  assign rs1_sign    = is_unsigned ? 1'b0 : i_rs1[XLEN-1];
  assign rs2_sign    = is_unsigned ? 1'b0 : i_rs2[XLEN-1];
  assign divisor     = {rs2_sign, rs2_sign, i_rs2};

  // Opposite signs start with a quotient digit of minus one
  assign quot_first = ~(rs1_sign ^ rs2_sign);

  // Previous digit picks subtract for plus one, add for minus one
  assign prev_quot = i_load ? quot_first : quot_r[0];

  // Low half of the shifting pair, dividend on load
  assign part_lo = i_load ? {i_rs1, quot_first} : quot_r;

  // Sign of each corrected step follows the remainder against the divisor
  assign remd_inc_quot_dec = remd_r[XLEN] ^ divisor[XLEN+1];

  //////////////////////////////////////////////////////////////////////////
  // Adder operand select per phase
  //////////////////////////////////////////////////////////////////////////

  always_comb begin
    if (i_quot_corr) begin
      add_op1 = {quot_r[XLEN], quot_r};
      add_op2 = {{(XLEN+1){1'b0}}, 1'b1};
      add_sub = remd_inc_quot_dec;
    end else if (i_chck | i_remd_corr) begin
      // Check adds the divisor to spot a remainder of minus divisor
      add_op1 = {remd_r[XLEN], remd_r};
      add_op2 = divisor;
      add_sub = i_remd_corr & ~remd_inc_quot_dec;
    end else begin
      // Load shifts the sign-extended dividend in from the top
      add_op1 = i_load ? {(XLEN+2){rs1_sign}} : {remd_sft1_r, remd_r};
      add_op2 = divisor;
      add_sub = prev_quot;
    end
  end

  assign add_res  = add_op1 + (add_op2 ^ {(XLEN+2){add_sub}}) + {{(XLEN+1){1'b0}}, add_sub};
  assign cur_quot = ~(add_res[XLEN+1] ^ divisor[XLEN+1]);

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      remd_r      <= '0;
      quot_r      <= '0;
      remd_sft1_r <= 1'b0;
    end else if (i_load | i_iter) begin
      // Partial remainder and quotient shift left together
      remd_r      <= {add_res[XLEN-1:0], part_lo[XLEN]};
      quot_r      <= {part_lo[XLEN-1:0], cur_quot};
      remd_sft1_r <= add_res[XLEN];
    end else if (i_last) begin
      // Unshifted remainder, final quotient digit is always one
      remd_r      <= add_res[XLEN:0];
      quot_r      <= {part_lo[XLEN-1:0], 1'b1};
      remd_sft1_r <= add_res[XLEN];
    end else if (i_quot_corr) begin
      quot_r <= add_res[XLEN:0];
    end
  end

  // Wrong sign, equal to divisor, or equal to minus divisor
  assign o_need_corr = i_chck & (((remd_r[XLEN] ^ rs1_sign) & (remd_r != '0)) |
                                 (add_res == '0) |
                                 (remd_r == divisor[XLEN:0]));

  // Corrected remainder goes out straight from the adder
  assign div_remd = i_remd_corr ? add_res[XLEN:0] : remd_r;

  assign o_div_res = ((i_op == OP_DIV) | (i_op == OP_DIVU)) ? quot_r[XLEN-1:0]
                                                             : div_remd[XLEN-1:0];

endmodule : nonrestore_div_dpath

`default_nettype wire

//--- logic/muldiv_wbck.sv
// Multiply/divide write-back
// Detects divide by zero and signed overflow, picks the result and
// drives the valid/ready handshake toward the core
`timescale 1ns/10ps
`default_nettype none

module muldiv_wbck (
  input  logic                        i_valid,
  input  logic                        i_o_ready,
  input  muldiv_pkg::muldiv_op_e      i_op,
  input  logic [muldiv_pkg::XLEN-1:0] i_rs1,
  input  logic [muldiv_pkg::XLEN-1:0] i_rs2,
  input  logic                        i_done,
  input  logic [muldiv_pkg::XLEN-1:0] i_mul_res,
  input  logic [muldiv_pkg::XLEN-1:0] i_div_res,
  output logic                        o_special,
  output logic                        o_retire,
  output logic                        o_valid,
  output logic                        o_i_ready,
  output logic [muldiv_pkg::XLEN-1:0] o_wdat
);

  import muldiv_pkg::*;

  logic            div_op;
  logic            quot_sel;
  logic            div_by_0;
  logic            div_ovf;
  logic            wbck_condi;
  logic [XLEN-1:0] special_res;

  assign quot_sel = (i_op == OP_DIV) | (i_op == OP_DIVU);
  assign div_op   = quot_sel | (i_op == OP_REM) | (i_op == OP_REMU);

  // Signed only, most negative over minus one
  assign div_by_0 = (i_rs2 == '0);
  assign div_ovf  = ((i_op == OP_DIV) | (i_op == OP_REM)) & (&i_rs2) &
                    (i_rs1 == {1'b1, {(XLEN-1){1'b0}}});

  // Only an operation on the port can be a special case
  assign o_special = i_valid & div_op & (div_by_0 | div_ovf);

  // RISC-V defined results for the two special cases
  always_comb begin
    if (div_by_0) begin
      special_res = quot_sel ? {XLEN{1'b1}} : i_rs1;
    end else begin
      special_res = quot_sel ? {1'b1, {(XLEN-1){1'b0}}} : '0;
    end
  end

  // Handshake passes through once a result exists
  assign wbck_condi = o_special | i_done;
  assign o_valid    = wbck_condi & i_valid;
  assign o_i_ready  = wbck_condi & i_o_ready;
  assign o_retire   = o_valid & i_o_ready;

  assign o_wdat = o_special ? special_res :
                  div_op    ? i_div_res   : i_mul_res;

endmodule : muldiv_wbck

`default_nettype wire

//--- logic/muldiv_top.sv
// Iterative multiply/divide unit top level
// Sequencer, Booth multiplier, non-restoring divider and write-back
`timescale 1ns/10ps
`default_nettype none

module muldiv_top (
  input  logic                        clk,
  input  logic                        i_arst_n,
  input  logic                        i_valid,
  input  muldiv_pkg::muldiv_op_e      i_op,
  input  logic [muldiv_pkg::XLEN-1:0] i_rs1,
  input  logic [muldiv_pkg::XLEN-1:0] i_rs2,
  input  logic                        o_ready,
  output logic                        i_ready,
  output logic                        o_valid,
  output logic [muldiv_pkg::XLEN-1:0] o_wdat
);

  import muldiv_pkg::*;

  // Sequencer strobes
  logic mul_load;
  logic mul_iter;
  logic mul_last;
  logic div_load;
  logic div_iter;
  logic div_last;
  logic div_chck;
  logic quot_corr;
  logic remd_corr;
  logic done;

  // Status back to the sequencer
  logic div_need_corr;
  logic special;
  logic retire;

  // Datapath results
  logic [XLEN-1:0] mul_res;
  logic [XLEN-1:0] div_res;

  muldiv_ctrl u_ctrl (
    .clk             (clk),
    .i_arst_n        (i_arst_n),
    .i_valid         (i_valid),
    .i_op            (i_op),
    .i_special       (special),
    .i_retire        (retire),
    .i_div_need_corr (div_need_corr),
    .o_mul_load      (mul_load),
    .o_mul_iter      (mul_iter),
    .o_mul_last      (mul_last),
    .o_div_load      (div_load),
    .o_div_iter      (div_iter),
    .o_div_last      (div_last),
    .o_div_chck      (div_chck),
    .o_quot_corr     (quot_corr),
    .o_remd_corr     (remd_corr),
    .o_done          (done)
  );

  booth_mul_dpath u_mul (
    .clk       (clk),
    .i_arst_n  (i_arst_n),
    .i_op      (i_op),
    .i_rs1     (i_rs1),
    .i_rs2     (i_rs2),
    .i_load    (mul_load),
    .i_iter    (mul_iter),
    .i_last    (mul_last),
    .o_mul_res (mul_res)
  );

  nonrestore_div_dpath u_div (
    .clk         (clk),
    .i_arst_n    (i_arst_n),
    .i_op        (i_op),
    .i_rs1       (i_rs1),
    .i_rs2       (i_rs2),
    .i_load      (div_load),
    .i_iter      (div_iter),
    .i_last      (div_last),
    .i_chck      (div_chck),
    .i_quot_corr (quot_corr),
    .i_remd_corr (remd_corr),
    .o_need_corr (div_need_corr),
    .o_div_res   (div_res)
  );

  muldiv_wbck u_wbck (
    .i_valid   (i_valid),
    .i_o_ready (o_ready),
    .i_op      (i_op),
    .i_rs1     (i_rs1),
    .i_rs2     (i_rs2),
    .i_done    (done),
    .i_mul_res (mul_res),
    .i_div_res (div_res),
    .o_special (special),
    .o_retire  (retire),
    .o_valid   (o_valid),
    .o_i_ready (i_ready),
    .o_wdat    (o_wdat)
  );

endmodule : muldiv_top

`default_nettype wire

//--- include/tb_muldiv_vectors.svh
// Directed multiply/divide vectors
// Corner operands for every opcode, with hand-derived results
`ifndef TB_MULDIV_VECTORS_SVH
`define TB_MULDIV_VECTORS_SVH

// Columns: {opcode[2:0], rs1[31:0], rs2[31:0], expected[31:0]}
localparam int NUM_VECTORS = 36;

localparam logic [98:0] VECTORS [0:NUM_VECTORS-1] = '{
  // Multiply, low word
  {OP_MUL,    32'h0000_0000, 32'h1234_5678, 32'h0000_0000},
  {OP_MUL,    32'h0000_0007, 32'h0000_0006, 32'h0000_002A},
  {OP_MUL,    32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'h0000_0001},
  {OP_MUL,    32'h8000_0000, 32'h8000_0000, 32'h0000_0000},
  // Multiply, high word with each signedness
  {OP_MULH,   32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'h0000_0000},
  {OP_MULH,   32'h8000_0000, 32'h8000_0000, 32'h4000_0000},
  {OP_MULH,   32'hFFFF_FFFE, 32'h0000_0003, 32'hFFFF_FFFF},
  {OP_MULH,   32'h1234_5678, 32'h0001_0000, 32'h0000_1234},
  {OP_MULHSU, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'hFFFF_FFFF},
  {OP_MULHSU, 32'h8000_0000, 32'h8000_0000, 32'hC000_0000},
  {OP_MULHU,  32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'hFFFF_FFFE},
  {OP_MULHU,  32'h0000_0000, 32'hFFFF_FFFF, 32'h0000_0000},
  {OP_MULHU,  32'h8000_0000, 32'h8000_0000, 32'h4000_0000},
  // Signed divide, exact and with negative operands
  {OP_DIV,    32'h0000_0014, 32'h0000_0005, 32'h0000_0004},
  {OP_REM,    32'h0000_0014, 32'h0000_0005, 32'h0000_0000},
  {OP_DIV,    32'hFFFF_FFEC, 32'h0000_0003, 32'hFFFF_FFFA},
  {OP_REM,    32'hFFFF_FFEC, 32'h0000_0003, 32'hFFFF_FFFE},
  {OP_DIV,    32'h0000_0014, 32'hFFFF_FFFD, 32'hFFFF_FFFA},
  {OP_REM,    32'h0000_0014, 32'hFFFF_FFFD, 32'h0000_0002},
  {OP_DIV,    32'hFFFF_FFEB, 32'hFFFF_FFF9, 32'h0000_0003},
  {OP_REM,    32'hFFFF_FFEB, 32'hFFFF_FFF9, 32'h0000_0000},
  {OP_DIV,    32'hFFFF_FFF9, 32'h0000_0007, 32'hFFFF_FFFF},
  {OP_REM,    32'hFFFF_FFF9, 32'h0000_0007, 32'h0000_0000},
  {OP_DIV,    32'h8000_0000, 32'h0000_0001, 32'h8000_0000},
  // Unsigned divide
  {OP_DIVU,   32'hFFFF_FFFF, 32'h0000_0002, 32'h7FFF_FFFF},
  {OP_REMU,   32'hFFFF_FFFF, 32'h0000_0002, 32'h0000_0001},
  {OP_DIVU,   32'h0000_0064, 32'h0000_000A, 32'h0000_000A},
  {OP_REMU,   32'h0000_0007, 32'h0000_0009, 32'h0000_0007},
  {OP_DIVU,   32'h8000_0000, 32'hFFFF_FFFF, 32'h0000_0000},
  {OP_REMU,   32'h8000_0000, 32'hFFFF_FFFF, 32'h8000_0000},
  // Divide by zero and signed overflow
  {OP_DIV,    32'h0000_1234, 32'h0000_0000, 32'hFFFF_FFFF},
  {OP_REM,    32'h0000_1234, 32'h0000_0000, 32'h0000_1234},
  {OP_DIVU,   32'h0000_0005, 32'h0000_0000, 32'hFFFF_FFFF},
  {OP_REMU,   32'hDEAD_BEEF, 32'h0000_0000, 32'hDEAD_BEEF},
  {OP_DIV,    32'h8000_0000, 32'hFFFF_FFFF, 32'h8000_0000},
  {OP_REM,    32'h8000_0000, 32'hFFFF_FFFF, 32'h0000_0000}
};

`endif

//--- tb/tb_muldiv.sv
// Multiply/divide unit testbench
// Directed table, then LFSR-driven random operations with back-pressure,
// each result compared with a 64-bit reference model
`timescale 1ns/10ps
`default_nettype none

module tb_muldiv;

  import muldiv_pkg::*;

  localparam int          TIMEOUT_CYCLES = 64;
  localparam int          RANDOM_OPS     = 200;
  localparam logic [31:0] LFSR_SEED      = 32'd91530;
  // Maximal-length 32-bit Galois feedback mask
  localparam logic [31:0] LFSR_TAPS      = 32'hB4BC_D35C;

  `include "tb_muldiv_vectors.svh"

  logic            clk;
  logic            i_arst_n;
  logic            i_valid;
  muldiv_op_e      i_op;
  logic [XLEN-1:0] i_rs1;
  logic [XLEN-1:0] i_rs2;
  logic            o_ready;
  logic            i_ready;
  logic            o_valid;
  logic [XLEN-1:0] o_wdat;
  logic [31:0]     lfsr_r;

  muldiv_top UUT (
    .clk      (clk),
    .i_arst_n (i_arst_n),
    .i_valid  (i_valid),
    .i_op     (i_op),
    .i_rs1    (i_rs1),
    .i_rs2    (i_rs2),
    .o_ready  (o_ready),
    .i_ready  (i_ready),
    .o_valid  (o_valid),
    .o_wdat   (o_wdat)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  // One LFSR step per bit, output bit shifted in at the bottom
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    int          i;
    val = '0;
    for (i = 0; i < n; i++) begin
      val    = {val[30:0], lfsr_r[0]};
      lfsr_r = lfsr_r[0] ? ((lfsr_r >> 1) ^ LFSR_TAPS) : (lfsr_r >> 1);
    end
    return val;
  endfunction

  // Reference model from 64-bit products and truncating division
  function automatic logic [31:0] ref_result(input muldiv_op_e op, input logic [31:0] a,
                                             input logic [31:0] b);
    logic signed [63:0] sa;
    logic signed [63:0] sb;
    logic signed [63:0] quot;
    logic signed [63:0] remd;
    logic [63:0]        prod;
    sa   = {{32{a[31]}}, a};
    sb   = {{32{b[31]}}, b};
    quot = '0;
    remd = '0;
    case (op)
      OP_MUL:    prod = sa * sb;
      OP_MULH:   prod = sa * sb;
      OP_MULHSU: prod = sa * $signed({32'b0, b});
      default:   prod = {32'b0, a} * {32'b0, b};
    endcase
    // Signed quotient and remainder, zero divisor answered below
    if (b != '0) begin
      quot = sa / sb;
      remd = sa % sb;
    end
    case (op)
      OP_MUL:  return prod[31:0];
      OP_DIV:  return (b == '0) ? 32'hFFFF_FFFF : quot[31:0];
      OP_REM:  return (b == '0) ? a : remd[31:0];
      OP_DIVU: return (b == '0) ? 32'hFFFF_FFFF : a / b;
      OP_REMU: return (b == '0) ? a : a % b;
      default: return prod[63:32];
    endcase
  endfunction

  task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("ERROR at %0t: %s, got %h, expected %h", $time, what, actual, expected);
      $display("Simulation finished: FAIL");
      $fatal(1, "mismatch");
    end
  endtask

  // Hold one operation until its result is taken, with stall cycles of o_ready low
  task automatic run_op(input muldiv_op_e op, input logic [31:0] a, input logic [31:0] b,
                        input logic [31:0] expected, input int stall);
    int    cycles;
    int    held;
    logic  is_div;
    logic  special;
    string tag;
    is_div  = (op == OP_DIV) | (op == OP_DIVU) | (op == OP_REM) | (op == OP_REMU);
    special = is_div & ((b == '0) | (((op == OP_DIV) | (op == OP_REM)) &
                                      (a == 32'h8000_0000) & (b == 32'hFFFF_FFFF)));
    tag     = $sformatf("%s %h %h", op.name(), a, b);
    @(negedge clk);
    i_valid = 1'b1;
    i_op    = op;
    i_rs1   = a;
    i_rs2   = b;
    o_ready = (stall == 0);
    cycles  = 0;
    #1;
    // Count rising edges until the result shows up
    while (!o_valid) begin
      if (cycles >= TIMEOUT_CYCLES) begin
        $display("Timeout: no o_valid for %s after %0d cycles", tag, cycles);
        $display("Simulation finished: FAIL");
        $fatal(1, "timeout");
      end
      @(negedge clk);
      #1;
      cycles++;
    end
    if (special) begin
      check_equal(32'(cycles), 32'd0, {tag, " special-case latency"});
    end else if (is_div) begin
      check_equal(32'((cycles == 33) || (cycles == 35)), 32'd1, {tag, " divide latency"});
    end else begin
      check_equal(32'(cycles), 32'd16, {tag, " multiply latency"});
    end
    // Sink stalls, result must hold and nothing is consumed
    for (held = 1; held <= stall; held++) begin
      check_equal(32'(i_ready), 32'd0, {tag, " i_ready under back-pressure"});
      check_equal(o_wdat, expected, {tag, " o_wdat under back-pressure"});
      @(negedge clk);
      if (held == stall) begin
        o_ready = 1'b1;
      end
      #1;
      check_equal(32'(o_valid), 32'd1, {tag, " o_valid under back-pressure"});
    end
    check_equal(32'(i_ready), 32'd1, {tag, " i_ready at hand-off"});
    check_equal(o_wdat, expected, {tag, " o_wdat"});
    // Taken once, the unit goes quiet when the source drops i_valid
    @(negedge clk);
    i_valid = 1'b0;
    #1;
    check_equal(32'(o_valid), 32'd0, {tag, " o_valid after hand-off"});
    check_equal(32'(i_ready), 32'd0, {tag, " i_ready after hand-off"});
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    logic [98:0] vec;
    muldiv_op_e  op;
    logic [31:0] a;
    logic [31:0] b;
    logic [1:0]  bias;
    int          idx;
    i_arst_n = 1'b0;
    i_valid  = 1'b0;
    i_op     = OP_MUL;
    i_rs1    = '0;
    i_rs2    = '0;
    o_ready  = 1'b0;
    lfsr_r   = LFSR_SEED;
    repeat (4) @(posedge clk);
    @(negedge clk);
    i_arst_n = 1'b1;
    o_ready  = 1'b1;
    // Idle after reset, no handshake activity
    for (idx = 0; idx < 6; idx++) begin
      #1;
      check_equal(32'(o_valid), 32'd0, "o_valid idle after reset");
      check_equal(32'(i_ready), 32'd0, "i_ready idle after reset");
      @(negedge clk);
    end
    // Directed table
    for (idx = 0; idx < NUM_VECTORS; idx++) begin
      vec = VECTORS[idx];
      run_op(muldiv_op_e'(vec[98:96]), vec[95:64], vec[63:32], vec[31:0], 0);
    end
    // Random mix, some divisors forced small or to minus one
    for (idx = 0; idx < RANDOM_OPS; idx++) begin
      op   = muldiv_op_e'(rand_bits(3));
      a    = rand_bits(32);
      b    = rand_bits(32);
      bias = 2'(rand_bits(2));
      if (bias == 2'd0) begin
        b = {28'b0, b[3:0]};
      end else if (bias == 2'd1) begin
        b = 32'hFFFF_FFFF;
      end
      run_op(op, a, b, ref_result(op, a, b), int'(rand_bits(2)));
    end
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule : tb_muldiv

`default_nettype wire

//--- sources.f
+incdir+include
logic/muldiv_pkg.sv
logic/muldiv_ctrl.sv
logic/booth_mul_dpath.sv
logic/nonrestore_div_dpath.sv
logic/muldiv_wbck.sv
logic/muldiv_top.sv
tb/tb_muldiv.sv

//--- Makefile
# Verilator build for the multiply/divide unit
# Override any variable on the command line, e.g. make sim TOP=tb_muldiv

TOP        ?= tb_muldiv
RTL_TOP    ?= muldiv_top
VERILATOR  ?= verilator
FILELIST   ?= sources.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only -Wall --timing

.PHONY: all lint sim clean

all: sim

# Lint the RTL top level, then the testbench with the RTL under it
lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# Build and run; a $fatal in the testbench gives a non-zero exit status
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
